/* src/neoIoPkg.sv */
package neoIoPkg;

	// Sizes of the cabinet I/O slice
	localparam int NUM_PORTS = 2;		// P1 and P2 joypads
	localparam int ADDR_W = 4;		// Word address seen by the slice
	localparam int DATA_W = 16;		// 68K data bus
	localparam int PAD_W = 10;		// Directions plus buttons, active low
	localparam int PADOUT_W = 3;		// Joypad output pins per port
	localparam int DIP_W = 8;
	localparam int STATUS_W = 4;		// Card detect, write protect, test button
	localparam int EL_W = 4;		// EL panel outputs
	localparam int LED_W = 9;		// Per LED output bank

	// Word address map of the I/O zone
	// Joypad port i answers at ADDR_PORT_BASE + i
	localparam logic [ADDR_W-1:0] ADDR_PORT_BASE = 4'd0;

	// DIP switch bank, read only
	localparam logic [ADDR_W-1:0] ADDR_DIP = 4'd8;

	// Card and test button status, read only
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'd9;

	// Addresses 10 and 11 stay unmapped

	// Shadow registers of the cabinet lamp driver, write only
	localparam logic [ADDR_W-1:0] ADDR_EL = 4'd12;
	localparam logic [ADDR_W-1:0] ADDR_LED1 = 4'd13;
	localparam logic [ADDR_W-1:0] ADDR_LED2 = 4'd14;

	// Latch strobe, copies all shadows to the pins
	localparam logic [ADDR_W-1:0] ADDR_LED_LATCH = 4'd15;

	// Floating bus reads back as all ones
	localparam logic [DATA_W-1:0] OPEN_BUS = {DATA_W{1'b1}};

endpackage

/* src/ioZoneDecode.sv */
`timescale 1ns/1ps

module ioZoneDecode (
	input  logic [neoIoPkg::ADDR_W-1:0]    addr,
	input  logic                           wrStb,
	output logic [neoIoPkg::NUM_PORTS-1:0] portRdSel,
	output logic                           dipRdSel,
	output logic                           statusRdSel,
	output logic [neoIoPkg::NUM_PORTS-1:0] portWr,
	output logic                           elWr,
	output logic                           led1Wr,
	output logic                           led2Wr,
	output logic                           latchWr
);

	// Address hits, independent of any strobe
	logic [neoIoPkg::NUM_PORTS-1:0] portHit;
	logic                           dipHit;
	logic                           statusHit;
	logic                           elHit;
	logic                           led1Hit;
	logic                           led2Hit;
	logic                           latchHit;

	always_comb
	begin
		// One joypad port per consecutive word from the base
		for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
		begin
			portHit[i] = (addr == neoIoPkg::ADDR_W'(neoIoPkg::ADDR_PORT_BASE + i));
		end
	end

	// Fixed single-word targets
	assign dipHit = (addr == neoIoPkg::ADDR_DIP);
	assign statusHit = (addr == neoIoPkg::ADDR_STATUS);
	assign elHit = (addr == neoIoPkg::ADDR_EL);
	assign led1Hit = (addr == neoIoPkg::ADDR_LED1);
	assign led2Hit = (addr == neoIoPkg::ADDR_LED2);
	assign latchHit = (addr == neoIoPkg::ADDR_LED_LATCH);

	// Read side
	// Selects are level signals, ioReadMux qualifies them with rdStb
	assign portRdSel = portHit;
	assign dipRdSel = dipHit;		// DIP bank
	assign statusRdSel = statusHit;		// Card and test status

	// Write side
	// Pulses already carry wrStb so targets load on a plain enable
	assign portWr = portHit & {neoIoPkg::NUM_PORTS{wrStb}};
	assign elWr = elHit & wrStb;		// EL shadow
	assign led1Wr = led1Hit & wrStb;	// LED bank 1 shadow
	assign led2Wr = led2Hit & wrStb;	// LED bank 2 shadow
	assign latchWr = latchHit & wrStb;	// Shadows to pins

	// DIP and status words are read only, a write there hits nothing
	// Lamp words are write only, a read there falls through to open bus

endmodule

/* src/joyPort.sv */
`timescale 1ns/1ps

module joyPort (
	input  logic                          MCLK,
	input  logic                          arstN,
	input  logic                          wr,		// Write pulse for this port only
	input  logic [neoIoPkg::PADOUT_W-1:0] wrData,
	input  logic [neoIoPkg::PAD_W-1:0]    padIn,		// Raw pins, asynchronous to MCLK
	output logic [neoIoPkg::PAD_W-1:0]    btnState,
	output logic [neoIoPkg::PADOUT_W-1:0] padOut
);

	// First synchronizer stage, may go metastable
	logic [neoIoPkg::PAD_W-1:0] padMeta;

	// Second stage drives btnState directly
	logic [neoIoPkg::PAD_W-1:0] padSync;

	// Output latch contents
	logic [neoIoPkg::PADOUT_W-1:0] outReg;

	// Button synchronizer
	// Pins are active low so reset to all ones means nothing pressed
	always_ff @(posedge MCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			padMeta <= {neoIoPkg::PAD_W{1'b1}};
			padSync <= {neoIoPkg::PAD_W{1'b1}};
		end
		else
		begin
			padMeta <= padIn;		// Stage 1
			padSync <= padMeta;		// Stage 2, safe to read
		end
	end

	// Two edges from pin to btnState
	assign btnState = padSync;

	// Joypad output latch
	// Only the low bits of the bus word reach the pins
	always_ff @(posedge MCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			outReg <= '0;		// Outputs idle low
		end
		else if (wr)
		begin
			outReg <= wrData;	// Loads on the edge that samples the write
		end
	end

	// Pins follow the latch without extra delay
	assign padOut = outReg;

	// The port has no read-back of its own outputs
	// Reads of this address return btnState through ioReadMux

	// Upper wrData bits never reach this block
	// neoIoTop slices the bus before the port

	// One instance per joypad connector
	// neoIoTop builds the array in a generate loop

endmodule

/* src/ioReadMux.sv */
`timescale 1ns/1ps

module ioReadMux (
	input  logic                                             MCLK,
	input  logic                                             arstN,
	input  logic                                             rdStb,
	input  logic [neoIoPkg::NUM_PORTS-1:0]                   portRdSel,
	input  logic                                             dipRdSel,
	input  logic                                             statusRdSel,
	input  logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PAD_W-1:0] btnState,
	input  logic [neoIoPkg::DIP_W-1:0]                       dipSw,
	input  logic [neoIoPkg::STATUS_W-1:0]                    status,
	output logic [neoIoPkg::DATA_W-1:0]                      rdData
);

	logic [neoIoPkg::DIP_W-1:0]    dipReg;		// Quasi-static, one flop is enough
	logic [neoIoPkg::STATUS_W-1:0] statusReg;
	logic [neoIoPkg::DATA_W-1:0]   rdNext;		// Word to load on rdStb

	// Slow inputs sampled every cycle
	always_ff @(posedge MCLK)
	begin
		dipReg <= dipSw;
		statusReg <= status;
	end

	// Source select
	// Decoder selects are one-hot, so later assignments never collide
	always_comb
	begin
		rdNext = neoIoPkg::OPEN_BUS;		// Unmapped and upper bits float high
		for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
		begin
			if (portRdSel[i])
				rdNext[neoIoPkg::PAD_W-1:0] = btnState[i];
		end
		if (dipRdSel)
			rdNext[neoIoPkg::DIP_W-1:0] = dipReg;
		if (statusRdSel)
			rdNext[neoIoPkg::STATUS_W-1:0] = statusReg;
	end

	// Read data register, holds until the next strobe
	always_ff @(posedge MCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			rdData <= neoIoPkg::OPEN_BUS;
		end
		else if (rdStb)
		begin
			rdData <= rdNext;
		end
	end

endmodule

/* src/ledLatch.sv */
`timescale 1ns/1ps

module ledLatch (
	input  logic                        MCLK,
	input  logic                        arstN,
	input  logic                        elWr,		// Shadow write pulses
	input  logic                        led1Wr,
	input  logic                        led2Wr,
	input  logic                        latchWr,	// Copy shadows to pins
	input  logic [neoIoPkg::DATA_W-1:0] wrData,
	output logic [neoIoPkg::EL_W-1:0]   elOut,
	output logic [neoIoPkg::LED_W-1:0]  ledOut1,
	output logic [neoIoPkg::LED_W-1:0]  ledOut2
);

	// Shadows written by the CPU, invisible until latched
	logic [neoIoPkg::EL_W-1:0]  elShadow;
	logic [neoIoPkg::LED_W-1:0] led1Shadow;
	logic [neoIoPkg::LED_W-1:0] led2Shadow;

	// Shadow stage
	// Each word has its own address, only one loads per write
	always_ff @(posedge MCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			elShadow <= '0;
			led1Shadow <= '0;
			led2Shadow <= '0;
		end
		else
		begin
			if (elWr)
				elShadow <= wrData[neoIoPkg::EL_W-1:0];		// Low nibble only
			if (led1Wr)
				led1Shadow <= wrData[neoIoPkg::LED_W-1:0];
			if (led2Wr)
				led2Shadow <= wrData[neoIoPkg::LED_W-1:0];
		end
	end

	// Output stage
	// All three banks switch on the same edge, so the lamps never
	// show a mix of old and new patterns
	always_ff @(posedge MCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			elOut <= '0;		// Lamps off
			ledOut1 <= '0;
			ledOut2 <= '0;
		end
		else if (latchWr)
		begin
			elOut <= elShadow;
			ledOut1 <= led1Shadow;
			ledOut2 <= led2Shadow;
		end
	end

	// A shadow write and the latch strobe sit on different addresses
	// The latch therefore always copies values from earlier writes

	// Data written along with the latch strobe is ignored
	// The strobe itself is the only information

	// Shadows are write only and do not appear on the read mux

endmodule

/* src/neoIoTop.sv */
`timescale 1ns/1ps

module neoIoTop (
	input  logic                                                 MCLK,
	input  logic                                                 arstN,
	input  logic [neoIoPkg::ADDR_W-1:0]                          addr,
	input  logic                                                 rdStb,
	input  logic                                                 wrStb,
	input  logic [neoIoPkg::DATA_W-1:0]                          wrData,
	output logic [neoIoPkg::DATA_W-1:0]                          rdData,
	input  logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PAD_W-1:0]  padIn,
	output logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PADOUT_W-1:0] padOut,
	input  logic [neoIoPkg::DIP_W-1:0]                           dipSw,
	input  logic                                                 cardDet1N,
	input  logic                                                 cardDet2N,
	input  logic                                                 wpN,
	input  logic                                                 testBtnN,
	output logic [neoIoPkg::EL_W-1:0]                            elOut,
	output logic [neoIoPkg::LED_W-1:0]                           ledOut1,
	output logic [neoIoPkg::LED_W-1:0]                           ledOut2
);

	logic [neoIoPkg::NUM_PORTS-1:0]                   portRdSel;
	logic                                             dipRdSel;
	logic                                             statusRdSel;
	logic [neoIoPkg::NUM_PORTS-1:0]                   portWr;
	logic                                             elWr;
	logic                                             led1Wr;
	logic                                             led2Wr;
	logic                                             latchWr;
	logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PAD_W-1:0] btnState;	// Synced buttons
	logic [neoIoPkg::STATUS_W-1:0]                    status;

	// Bit 3 down to bit 0 as the CPU sees them
	assign status = {cardDet1N, cardDet2N, wpN, testBtnN};

	ioZoneDecode decode (
		.addr       (addr),
		.wrStb      (wrStb),
		.portRdSel  (portRdSel),
		.dipRdSel   (dipRdSel),
		.statusRdSel(statusRdSel),
		.portWr     (portWr),
		.elWr       (elWr),
		.led1Wr     (led1Wr),
		.led2Wr     (led2Wr),
		.latchWr    (latchWr)
	);

	// One block per joypad connector
	genvar gPort;
	generate
		for (gPort = 0; gPort < neoIoPkg::NUM_PORTS; gPort++)
		begin : genPort
			joyPort port (
				.MCLK    (MCLK),
				.arstN   (arstN),
				.wr      (portWr[gPort]),
				.wrData  (wrData[neoIoPkg::PADOUT_W-1:0]),	// Low bits drive the pins
				.padIn   (padIn[gPort]),
				.btnState(btnState[gPort]),
				.padOut  (padOut[gPort])
			);
		end
	endgenerate

	ioReadMux readMux (
		.MCLK       (MCLK),
		.arstN      (arstN),
		.rdStb      (rdStb),
		.portRdSel  (portRdSel),
		.dipRdSel   (dipRdSel),
		.statusRdSel(statusRdSel),
		.btnState   (btnState),
		.dipSw      (dipSw),
		.status     (status),
		.rdData     (rdData)
	);

	ledLatch lamps (
		.MCLK   (MCLK),
		.arstN  (arstN),
		.elWr   (elWr),
		.led1Wr (led1Wr),
		.led2Wr (led2Wr),
		.latchWr(latchWr),
		.wrData (wrData),
		.elOut  (elOut),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2)
	);

endmodule

/* tests/tbNeoIo.sv */
`timescale 1ns/1ps

module tbNeoIo;

	localparam int NUM_TESTS = 6;
	localparam int OPS_PER_TEST = 48;		// Generous bound on bus ops per test
	localparam int WATCHDOG_CYCLES = NUM_TESTS * OPS_PER_TEST * 10;
	localparam logic [15:0] OPEN_BUS = neoIoPkg::OPEN_BUS;

	logic                                                   MCLK;
	logic                                                   arstN;
	logic [neoIoPkg::ADDR_W-1:0]                            addr;
	logic                                                   rdStb;
	logic                                                   wrStb;
	logic [neoIoPkg::DATA_W-1:0]                            wrData;
	logic [neoIoPkg::DATA_W-1:0]                            rdData;
	logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PAD_W-1:0]    padIn;
	logic [neoIoPkg::NUM_PORTS-1:0][neoIoPkg::PADOUT_W-1:0] padOut;
	logic [neoIoPkg::DIP_W-1:0]                             dipSw;
	logic                                                   cardDet1N;
	logic                                                   cardDet2N;
	logic                                                   wpN;
	logic                                                   testBtnN;
	logic [neoIoPkg::EL_W-1:0]                              elOut;
	logic [neoIoPkg::LED_W-1:0]                             ledOut1;
	logic [neoIoPkg::LED_W-1:0]                             ledOut2;

	int          errCount = 0;
	int          testCount = 0;
	int          failedTests = 0;
	logic [31:0] lcgState = 32'd17602;
	logic [neoIoPkg::PADOUT_W-1:0] padOutExp [neoIoPkg::NUM_PORTS];	// Model of each port latch
	logic [15:0] elExp;		// Expected visible lamp outputs
	logic [15:0] led1Exp;
	logic [15:0] led2Exp;

	neoIoTop i_dut (
		.MCLK     (MCLK),
		.arstN    (arstN),
		.addr     (addr),
		.rdStb    (rdStb),
		.wrStb    (wrStb),
		.wrData   (wrData),
		.rdData   (rdData),
		.padIn    (padIn),
		.padOut   (padOut),
		.dipSw    (dipSw),
		.cardDet1N(cardDet1N),
		.cardDet2N(cardDet2N),
		.wpN      (wpN),
		.testBtnN (testBtnN),
		.elOut    (elOut),
		.ledOut1  (ledOut1),
		.ledOut2  (ledOut2)
	);

	initial
	begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;		// 8 ns period
	end

	// Lamp pins move only on the edge that samples a latch write
	assert property (@(posedge MCLK) disable iff (!arstN)
		!(wrStb && addr == neoIoPkg::ADDR_LED_LATCH) |=> $stable({elOut, ledOut1, ledOut2}))
	else
	begin
		$display("Lamp outputs changed without a latch write");
		errCount++;
	end

	// Read data holds between strobes
	assert property (@(posedge MCLK) disable iff (!arstN) !rdStb |=> $stable(rdData))
	else
	begin
		$display("rdData changed without a read strobe");
		errCount++;
	end

	// LCG step, numerical recipes constants
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Open bus above a field of the given width
	function automatic logic [15:0] fillOpenBus(input logic [15:0] low, input int width);
		logic [15:0] mask;
		mask = OPEN_BUS << width;
		return mask | (low & ~mask);
	endfunction

	task automatic checkValue(input string sigName, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h expected %h", sigName, got, exp);
			errCount++;
		end
	endtask

	// One cycle strobe, data is stable by the following falling edge
	task automatic busRead(input logic [neoIoPkg::ADDR_W-1:0] a, output logic [15:0] data);
		@(posedge MCLK);
		addr <= a;
		rdStb <= 1'b1;
		@(posedge MCLK);		// DUT samples the strobe here
		rdStb <= 1'b0;
		@(negedge MCLK);
		data = rdData;
	endtask

	task automatic busWrite(input logic [neoIoPkg::ADDR_W-1:0] a, input logic [15:0] d);
		@(posedge MCLK);
		addr <= a;
		wrData <= d;
		wrStb <= 1'b1;
		@(posedge MCLK);
		wrStb <= 1'b0;
		@(negedge MCLK);		// Outputs settled
	endtask

	task automatic checkOutputs();
		for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
			checkValue($sformatf("padOut[%0d]", i), 16'(padOut[i]), 16'(padOutExp[i]));
		checkValue("elOut", 16'(elOut), elExp);
		checkValue("ledOut1", 16'(ledOut1), led1Exp);
		checkValue("ledOut2", 16'(ledOut2), led2Exp);
	endtask

	task automatic endTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
		begin
			$display("Test %0d %s: ok", testCount, name);
		end
		else
		begin
			$display("Test %0d %s: %0d mismatches", testCount, name, errCount - errBefore);
			failedTests++;
		end
	endtask

	task automatic testReset();
		int          errBefore;
		logic [15:0] d;
		errBefore = errCount;
		checkValue("rdData", rdData, OPEN_BUS);
		checkOutputs();
		for (int a = 0; a < 16; a++)
		begin
			busRead(4'(a), d);
			if (a == 8)
				checkValue("rdData", d, fillOpenBus(16'(dipSw), neoIoPkg::DIP_W));
			else if (a == 9)
				checkValue("rdData", d, fillOpenBus(16'(4'b1011), neoIoPkg::STATUS_W));
			else
				checkValue("rdData", d, OPEN_BUS);		// Released pads, holes, lamp words
		end
		endTest("reset state", errBefore);
	endtask

	task automatic testPadReads();
		int          errBefore;
		logic [31:0] r;
		logic [9:0]  pads [neoIoPkg::NUM_PORTS];
		logic [15:0] d;
		errBefore = errCount;
		for (int round = 0; round < 8; round++)
		begin
			@(posedge MCLK);
			for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
			begin
				r = nextRand();
				pads[i] = r[17:8];
				padIn[i] <= r[17:8];
			end
			repeat (3) @(posedge MCLK);		// Through both synchronizer stages
			for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
			begin
				busRead(4'(neoIoPkg::ADDR_PORT_BASE + i), d);
				checkValue($sformatf("rdData port %0d", i), d,
					fillOpenBus(16'(pads[i]), neoIoPkg::PAD_W));
			end
		end
		endTest("pad reads", errBefore);
	endtask

	task automatic testPadOutputs();
		int          errBefore;
		logic [31:0] r;
		errBefore = errCount;
		for (int round = 0; round < 4; round++)
		begin
			for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
			begin
				r = nextRand();
				padOutExp[i] = r[18:16];		// Other port keeps its model value
				busWrite(4'(neoIoPkg::ADDR_PORT_BASE + i), r[31:16]);
				checkOutputs();
			end
		end
		endTest("port outputs", errBefore);
	endtask

	task automatic testDipStatus();
		int          errBefore;
		logic [31:0] r;
		logic [15:0] d;
		logic [7:0]  dipVal;
		logic [3:0]  stVal;
		errBefore = errCount;
		for (int round = 0; round < 6; round++)
		begin
			r = nextRand();
			dipVal = r[23:16];
			stVal = r[27:24];		// cardDet1N, cardDet2N, wpN, testBtnN
			@(posedge MCLK);
			dipSw <= dipVal;
			cardDet1N <= stVal[3];
			cardDet2N <= stVal[2];
			wpN <= stVal[1];
			testBtnN <= stVal[0];
			repeat (2) @(posedge MCLK);
			busRead(neoIoPkg::ADDR_DIP, d);
			checkValue("rdData dip", d, fillOpenBus(16'(dipVal), neoIoPkg::DIP_W));
			busRead(neoIoPkg::ADDR_STATUS, d);
			checkValue("rdData status", d, fillOpenBus(16'(stVal), neoIoPkg::STATUS_W));
		end
		endTest("dip and status", errBefore);
	endtask

	task automatic testLedLatch();
		int          errBefore;
		logic [31:0] r;
		logic [15:0] elW;
		logic [15:0] led1W;
		logic [15:0] led2W;
		errBefore = errCount;
		for (int round = 0; round < 3; round++)
		begin
			r = nextRand();
			elW = r[31:16];
			busWrite(neoIoPkg::ADDR_EL, elW);
			checkOutputs();		// Shadows only, pins unchanged
			r = nextRand();
			led1W = r[31:16];
			busWrite(neoIoPkg::ADDR_LED1, led1W);
			checkOutputs();
			r = nextRand();
			led2W = r[31:16];
			busWrite(neoIoPkg::ADDR_LED2, led2W);
			checkOutputs();
			elExp = 16'(elW[neoIoPkg::EL_W-1:0]);
			led1Exp = 16'(led1W[neoIoPkg::LED_W-1:0]);
			led2Exp = 16'(led2W[neoIoPkg::LED_W-1:0]);
			r = nextRand();
			busWrite(neoIoPkg::ADDR_LED_LATCH, r[31:16]);		// Data ignored
			checkOutputs();
		end
		endTest("led latch", errBefore);
	endtask

	task automatic testUnmapped();
		int          errBefore;
		logic [31:0] r;
		logic [15:0] d;
		int          holes [8];
		errBefore = errCount;
		holes = '{2, 3, 4, 5, 6, 7, 10, 11};
		foreach (holes[k])
		begin
			busRead(4'(holes[k]), d);
			checkValue($sformatf("rdData addr %0d", holes[k]), d, OPEN_BUS);
			r = nextRand();
			busWrite(4'(holes[k]), r[31:16]);
			checkOutputs();
		end
		// Latch again, shadows must still hold the values seen on the pins
		busWrite(neoIoPkg::ADDR_LED_LATCH, 16'h0000);
		checkOutputs();
		endTest("unmapped addresses", errBefore);
	endtask

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge MCLK);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		arstN <= 1'b0;
		addr <= '0;
		rdStb <= 1'b0;
		wrStb <= 1'b0;
		wrData <= '0;
		padIn <= '1;		// All buttons released
		dipSw <= 8'hA5;
		cardDet1N <= 1'b1;
		cardDet2N <= 1'b0;
		wpN <= 1'b1;
		testBtnN <= 1'b1;
		for (int i = 0; i < neoIoPkg::NUM_PORTS; i++)
			padOutExp[i] = '0;
		elExp = '0;
		led1Exp = '0;
		led2Exp = '0;
		repeat (3) @(posedge MCLK);
		arstN <= 1'b1;
		@(negedge MCLK);

		testReset();
		testPadReads();
		testPadOutputs();
		testDipStatus();
		testLedLatch();
		testUnmapped();

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			testCount, failedTests, errCount);
		if (errCount == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* flist.f */
src/neoIoPkg.sv
src/ioZoneDecode.sv
src/joyPort.sv
src/ioReadMux.sv
src/ledLatch.sv
src/neoIoTop.sv
tests/tbNeoIo.sv

/* Makefile */
# Verilator simulation of the cabinet I/O slice
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tbNeoIo
FLIST     ?= flist.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
